/* filelist.f */
source/harness_pkg.sv
source/req_arbiter.sv
source/addr_decoder.sv
source/boot_rom.sv
source/sram.sv
source/machine_timer.sv
source/harness_top.sv
test/harness_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the harness testbench with Verilator, run it and check the log

set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module harness_tb \
    -f filelist.f \
    -o harness_sim

./obj_dir/harness_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
    echo "Simulation result: pass"
    exit 0
fi

echo "Simulation result: fail"
exit 1

/* test/harness_cases.txt */
# name port op addr be wdata exp_rdata exp_err exp_irq
# port 0 core 1 debug, op 0 read 1 write, addr be wdata exp_rdata in hex
rom_w0_core      0 0 00010000 f 00000000 800002b7 0 0
rom_w1_dbg       1 0 00010004 f 00000000 00028067 0 0
rom_w2_core      0 0 00010008 f 00000000 00000013 0 0
rom_w15_dbg      1 0 0001003c f 00000000 00000013 0 0
rom_wr_core      0 1 00010004 f 12345678 00000000 1 0
rom_wr_dbg       1 1 00010000 f deadbeef 00000000 1 0
rom_w0_after_wr  1 0 00010000 f 00000000 800002b7 0 0
rom_past_end     0 0 00010040 f 00000000 00000000 1 0
sram_wr_full     0 1 80000010 f 11223344 00000000 0 0
sram_wr_be5      1 1 80000010 5 aabbccdd 00000000 0 0
sram_rd_be5      0 0 80000010 f 00000000 11bb33dd 0 0
sram_wr_be8      0 1 80000010 8 ee000000 00000000 0 0
sram_rd_be8      1 0 80000010 f 00000000 eebb33dd 0 0
sram_wr_last     1 1 800003fc f cafef00d 00000000 0 0
sram_wr_last_b1  0 1 800003fc 2 00005500 00000000 0 0
sram_rd_last     1 0 800003fc f 00000000 cafe550d 0 0
sram_past_end    0 0 80000400 f 00000000 00000000 1 0
unmapped_core    0 0 40000000 f 00000000 00000000 1 0
unmapped_dbg     1 1 40000000 f 12345678 00000000 1 0
unmapped_top     0 0 fffffffc f 00000000 00000000 1 0
cmp_rd_reset     1 0 02000004 f 00000000 ffffffff 0 0
cmp_wr_zero      0 1 02000004 f 00000000 00000000 0 1
cmp_rd_zero      1 0 02000004 f 00000000 00000000 0 1
timer_gap        0 0 02000008 f 00000000 00000000 1 1
cmp_wr_ones      1 1 02000004 f ffffffff 00000000 0 0
cmp_rd_ones      0 0 02000004 f 00000000 ffffffff 0 0

/* test/harness_tb.sv */
// Testbench for the harness subsystem
// Directed cases from a file, then random SRAM traffic on both ports

`default_nettype none

module harness_tb import harness_pkg::*; ();

    localparam int MAX_CASES      = 64;
    localparam int RAND_PER_PORT  = 32;
    localparam int RAND_BASE_WORD = 32;

    logic      clk;
    logic      rst_n;
    bus_req_t  core_req;
    logic      core_req_valid;
    logic      core_req_ready;
    bus_resp_t core_resp;
    logic      core_resp_valid;
    logic      core_resp_ready;
    bus_req_t  dbg_req;
    logic      dbg_req_valid;
    logic      dbg_req_ready;
    bus_resp_t dbg_resp;
    logic      dbg_resp_valid;
    logic      dbg_resp_ready;
    logic      timer_irq;

    string       case_name  [MAX_CASES];
    int          case_port  [MAX_CASES];
    int          case_op    [MAX_CASES];
    logic [31:0] case_addr  [MAX_CASES];
    logic [3:0]  case_be    [MAX_CASES];
    logic [31:0] case_wdata [MAX_CASES];
    logic [31:0] case_rdata [MAX_CASES];
    int          case_err   [MAX_CASES];
    int          case_irq   [MAX_CASES];
    int          n_cases;

    // Shadow of the SRAM words used by the random phase
    logic [31:0] shadow  [SRAM_WORDS];
    bit          written [SRAM_WORDS];
    bit          rand_ok    [2];

    integer seed;
    int     cycles      = 0;
    int     cycle_limit = 1000000;
    int     pass_count  = 0;
    int     fail_count  = 0;
    string  core_case   = "idle";
    string  dbg_case    = "idle";

    harness_top harness_top_i (
        .clk_i             ( clk             ),
        .rst_n_i           ( rst_n           ),
        .core_req_i        ( core_req        ),
        .core_req_valid_i  ( core_req_valid  ),
        .core_req_ready_o  ( core_req_ready  ),
        .core_resp_o       ( core_resp       ),
        .core_resp_valid_o ( core_resp_valid ),
        .core_resp_ready_i ( core_resp_ready ),
        .dbg_req_i         ( dbg_req         ),
        .dbg_req_valid_i   ( dbg_req_valid   ),
        .dbg_req_ready_o   ( dbg_req_ready   ),
        .dbg_resp_o        ( dbg_resp        ),
        .dbg_resp_valid_o  ( dbg_resp_valid  ),
        .dbg_resp_ready_i  ( dbg_resp_ready  ),
        .timer_irq_o       ( timer_irq       )
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, core port in %0s, debug port in %0s",
                     cycles, core_case, dbg_case);
            fail_count++;
            finish_run();
        end
    end

    // ------------------------------------------------------------------------
    // Port access helpers
    // ------------------------------------------------------------------------
    function automatic logic req_valid_of(input int port);
        return (port == 0) ? core_req_valid : dbg_req_valid;
    endfunction

    function automatic logic req_ready_of(input int port);
        return (port == 0) ? core_req_ready : dbg_req_ready;
    endfunction

    function automatic logic resp_valid_of(input int port);
        return (port == 0) ? core_resp_valid : dbg_resp_valid;
    endfunction

    function automatic logic resp_ready_of(input int port);
        return (port == 0) ? core_resp_ready : dbg_resp_ready;
    endfunction

    function automatic bus_resp_t resp_of(input int port);
        return (port == 0) ? core_resp : dbg_resp;
    endfunction

    task automatic drive_req(input int port, input bit valid, input bus_req_t req);
        if (port == 0) begin
            core_req       = req;
            core_req_valid = valid;
        end else begin
            dbg_req       = req;
            dbg_req_valid = valid;
        end
    endtask

    task automatic set_resp_ready(input int port, input bit ready);
        if (port == 0) begin
            core_resp_ready = ready;
        end else begin
            dbg_resp_ready = ready;
        end
    endtask

    task automatic note_case(input int port, input string name);
        if (port == 0) begin
            core_case = name;
        end else begin
            dbg_case = name;
        end
    endtask

    // Old bytes where be is 0, new bytes where be is 1
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // ------------------------------------------------------------------------
    // Checking and reporting
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, inout bit ok);
        if (actual !== expected) begin
            $display("** Error: %0s expected %h actual %h", name, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            pass_count++;
            $display("ok    %0s", name);
        end else begin
            fail_count++;
            $display("FAIL  %0s", name);
        end
    endtask

    task automatic finish_run();
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // Responses must stay on their own port and a held response blocks requests
    task automatic watch_ports(input int port, input bit solo, input string name,
                               inout bit ok);
        if (resp_valid_of(port)) begin
            $display("%0s: response on port %0d before its request was taken", name, port);
            ok = 1'b0;
        end
        if (solo && resp_valid_of(1 - port)) begin
            $display("%0s: response appeared on the idle port %0d", name, 1 - port);
            ok = 1'b0;
        end
        if (core_resp_valid || dbg_resp_valid) begin
            check_value({name, " req_ready with response held"}, 32'd0,
                        32'(req_ready_of(port)), ok);
        end
    endtask

    // ------------------------------------------------------------------------
    // Transactions
    // ------------------------------------------------------------------------
    // Returns just before the rising edge that takes the request
    task automatic send_req(input int port, input bus_req_t req, input bit solo,
                            input string name, inout bit ok);
        int other_grants;
        other_grants = 0;
        @(negedge clk);
        drive_req(port, 1'b1, req);
        #1;
        while (!req_ready_of(port)) begin
            watch_ports(port, solo, name, ok);
            // Round robin lets the other port in at most once while this one waits
            if (req_valid_of(1 - port) && req_ready_of(1 - port)) begin
                other_grants++;
            end
            @(negedge clk);
            #1;
        end
        watch_ports(port, solo, name, ok);
        if (other_grants > 1) begin
            $display("%0s: port %0d was passed over %0d times while its request waited",
                     name, port, other_grants);
            ok = 1'b0;
        end
    endtask

    task automatic wait_resp(input int port, input bit solo, input string name,
                             output bus_resp_t resp, output logic irq, inout bit ok);
        @(negedge clk);
        drive_req(port, 1'b0, '0);
        set_resp_ready(port, solo ? 1'b1 : (($random(seed) & 3) != 0));
        #1;
        while (!(resp_valid_of(port) && resp_ready_of(port))) begin
            if (solo && resp_valid_of(1 - port)) begin
                $display("%0s: response appeared on the idle port %0d", name, 1 - port);
                ok = 1'b0;
            end
            @(negedge clk);
            set_resp_ready(port, solo ? 1'b1 : (($random(seed) & 3) != 0));
            #1;
        end
        resp = resp_of(port);
        irq  = timer_irq;
    endtask

    task automatic read_cases(output bit opened);
        integer           fd;
        integer           count;
        logic [8*160-1:0] line_buf;
        logic [8*32-1:0]  name_buf;
        int               port;
        int               op;
        int               err;
        int               irq;
        logic [31:0]      addr;
        logic [31:0]      wdata;
        logic [31:0]      rdata;
        logic [3:0]       be;
        n_cases = 0;
        fd      = $fopen("test/harness_cases.txt", "r");
        opened  = (fd != 0);
        if (opened) begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                line_buf = '0;
                count    = $fgets(line_buf, fd);
                count    = $sscanf(line_buf, "%s %d %d %h %h %h %h %d %d", name_buf,
                                   port, op, addr, be, wdata, rdata, err, irq);
                // Comment and blank lines never give all nine fields
                if (count == 9) begin
                    case_name[n_cases]  = string'(name_buf);
                    case_port[n_cases]  = port;
                    case_op[n_cases]    = op;
                    case_addr[n_cases]  = addr;
                    case_be[n_cases]    = be;
                    case_wdata[n_cases] = wdata;
                    case_rdata[n_cases] = rdata;
                    case_err[n_cases]   = err;
                    case_irq[n_cases]   = irq;
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_directed();
        bus_req_t  req;
        bus_resp_t resp;
        logic      irq;
        bit        ok;
        string     name;
        for (int i = 0; i < n_cases; i++) begin
            ok   = 1'b1;
            name = case_name[i];
            note_case(case_port[i], name);
            note_case(1 - case_port[i], "idle");
            req       = '0;
            req.op    = bus_op_e'(case_op[i]);
            req.addr  = case_addr[i];
            req.be    = case_be[i];
            req.wdata = case_wdata[i];
            send_req(case_port[i], req, 1'b1, name, ok);
            wait_resp(case_port[i], 1'b1, name, resp, irq, ok);
            check_value({name, " rdata"}, case_rdata[i], resp.rdata, ok);
            check_value({name, " err"}, case_err[i], 32'(resp.err), ok);
            check_value({name, " src"}, case_port[i], 32'(resp.src), ok);
            check_value({name, " irq"}, case_irq[i], 32'(irq), ok);
            report_test(name, ok);
        end
    endtask

    task automatic random_traffic(input int port);
        bus_req_t    req;
        bus_resp_t   resp;
        logic        irq;
        logic [31:0] expected;
        int          idx;
        bit          ok;
        string       name;
        ok = 1'b1;
        for (int n = 0; n < RAND_PER_PORT; n++) begin
            name = $sformatf("rand_%0s_%0d", (port == 0) ? "core" : "dbg", n);
            note_case(port, name);
            repeat ($random(seed) & 3) @(negedge clk);
            idx       = RAND_BASE_WORD + ($random(seed) & 15);
            req       = '0;
            req.addr  = SRAM_BASE + 32'(idx * 4);
            req.op    = (written[idx] && ($random(seed) & 1)) ? OP_READ : OP_WRITE;
            req.wdata = $random(seed);
            req.be    = 4'($random(seed));
            // First write to a word fills it so later reads are fully known
            if (!written[idx] || req.be == 4'h0) begin
                req.be = 4'hf;
            end
            send_req(port, req, 1'b0, name, ok);
            // Requests reach the SRAM in the order they are taken here
            if (req.op == OP_WRITE) begin
                shadow[idx]  = merge_bytes(shadow[idx], req.wdata, req.be);
                written[idx] = 1'b1;
                expected     = '0;
            end else begin
                expected = shadow[idx];
            end
            wait_resp(port, 1'b0, name, resp, irq, ok);
            check_value({name, " rdata"}, expected, resp.rdata, ok);
            check_value({name, " err"}, 32'd0, 32'(resp.err), ok);
            check_value({name, " src"}, port, 32'(resp.src), ok);
        end
        note_case(port, "idle");
        rand_ok[port] = ok;
    endtask

    task automatic run_random();
        fork
            random_traffic(0);
            random_traffic(1);
        join
        report_test("rand_core", rand_ok[0]);
        report_test("rand_dbg", rand_ok[1]);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        bit opened;
        bit ok;
        clk             = 1'b0;
        rst_n           = 1'b0;
        core_req        = '0;
        core_req_valid  = 1'b0;
        core_resp_ready = 1'b0;
        dbg_req         = '0;
        dbg_req_valid   = 1'b0;
        dbg_resp_ready  = 1'b0;
        seed            = 32'hfaf1ddc5;
        for (int i = 0; i < SRAM_WORDS; i++) begin
            written[i] = 1'b0;
        end

        read_cases(opened);
        if (!opened || n_cases == 0) begin
            $display("Could not read any case from test/harness_cases.txt");
            fail_count++;
        end else begin
            cycle_limit = 20 * n_cases + 40 * 2 * RAND_PER_PORT + 20;
            repeat (8) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;

            // Nothing valid and no interrupt straight after reset
            ok = 1'b1;
            #1;
            check_value("reset core_resp_valid", 32'd0, 32'(core_resp_valid), ok);
            check_value("reset dbg_resp_valid", 32'd0, 32'(dbg_resp_valid), ok);
            check_value("reset timer_irq", 32'd0, 32'(timer_irq), ok);
            report_test("reset_state", ok);

            run_directed();
            run_random();
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* source/harness_top.sv */
// Harness subsystem top level
// Core and debug ports share ROM, SRAM and machine timer through one decoder

`default_nettype none

module harness_top import harness_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  bus_req_t  core_req_i,
    input  logic      core_req_valid_i,
    output logic      core_req_ready_o,
    output bus_resp_t core_resp_o,
    output logic      core_resp_valid_o,
    input  logic      core_resp_ready_i,
    input  bus_req_t  dbg_req_i,
    input  logic      dbg_req_valid_i,
    output logic      dbg_req_ready_o,
    output bus_resp_t dbg_resp_o,
    output logic      dbg_resp_valid_o,
    input  logic      dbg_resp_ready_i,
    output logic      timer_irq_o
);

    bus_req_t            arb_req;
    logic                arb_req_valid;
    logic                arb_req_ready;
    bus_resp_t           dec_resp;
    logic                dec_resp_valid;
    logic                dec_resp_ready;

    logic                rom_req;
    logic                sram_req;
    logic                timer_req;
    logic                tgt_we;
    logic [ADDR_W-1:0]   tgt_addr;
    logic [DATA_W/8-1:0] tgt_be;
    logic [DATA_W-1:0]   tgt_wdata;
    logic [DATA_W-1:0]   rom_rdata;
    logic [DATA_W-1:0]   sram_rdata;
    logic [DATA_W-1:0]   timer_rdata;

    // ------------------------------------------------------------------------
    // Arbiter and decoder
    // ------------------------------------------------------------------------
    req_arbiter i_req_arbiter (
        .clk_i,
        .rst_n_i,
        .core_req_i,
        .core_req_valid_i,
        .core_req_ready_o,
        .core_resp_o,
        .core_resp_valid_o,
        .core_resp_ready_i,
        .dbg_req_i,
        .dbg_req_valid_i,
        .dbg_req_ready_o,
        .dbg_resp_o,
        .dbg_resp_valid_o,
        .dbg_resp_ready_i,
        .arb_req_o        ( arb_req        ),
        .arb_req_valid_o  ( arb_req_valid  ),
        .arb_req_ready_i  ( arb_req_ready  ),
        .dec_resp_i       ( dec_resp       ),
        .dec_resp_valid_i ( dec_resp_valid ),
        .dec_resp_ready_o ( dec_resp_ready )
    );

    addr_decoder i_addr_decoder (
        .clk_i,
        .rst_n_i,
        .req_i         ( arb_req        ),
        .req_valid_i   ( arb_req_valid  ),
        .req_ready_o   ( arb_req_ready  ),
        .resp_o        ( dec_resp       ),
        .resp_valid_o  ( dec_resp_valid ),
        .resp_ready_i  ( dec_resp_ready ),
        .rom_req_o     ( rom_req        ),
        .sram_req_o    ( sram_req       ),
        .timer_req_o   ( timer_req      ),
        .tgt_we_o      ( tgt_we         ),
        .tgt_addr_o    ( tgt_addr       ),
        .tgt_be_o      ( tgt_be         ),
        .tgt_wdata_o   ( tgt_wdata      ),
        .rom_rdata_i   ( rom_rdata      ),
        .sram_rdata_i  ( sram_rdata     ),
        .timer_rdata_i ( timer_rdata    )
    );

    // ------------------------------------------------------------------------
    // Targets
    // ------------------------------------------------------------------------
    // Word index sits above the two byte offset bits
    boot_rom i_boot_rom (
        .clk_i,
        .req_i   ( rom_req                           ),
        .addr_i  ( tgt_addr[2 +: $clog2(ROM_WORDS)]  ),
        .rdata_o ( rom_rdata                         )
    );

    sram i_sram (
        .clk_i,
        .req_i   ( sram_req                          ),
        .we_i    ( tgt_we                            ),
        .addr_i  ( tgt_addr[2 +: $clog2(SRAM_WORDS)] ),
        .be_i    ( tgt_be                            ),
        .wdata_i ( tgt_wdata                         ),
        .rdata_o ( sram_rdata                        )
    );

    machine_timer i_machine_timer (
        .clk_i,
        .rst_n_i,
        .req_i       ( timer_req   ),
        .we_i        ( tgt_we      ),
        .addr_i      ( tgt_addr[2] ),
        .be_i        ( tgt_be      ),
        .wdata_i     ( tgt_wdata   ),
        .rdata_o     ( timer_rdata ),
        .timer_irq_o
    );

endmodule

`default_nettype wire

/* source/machine_timer.sv */
// Machine timer with mtime and mtimecmp registers
// Raises the timer interrupt while mtime is at or above mtimecmp

`default_nettype none

module machine_timer import harness_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_i,
    input  logic                we_i,
    input  logic                addr_i,
    input  logic [DATA_W/8-1:0] be_i,
    input  logic [DATA_W-1:0]   wdata_i,
    output logic [DATA_W-1:0]   rdata_o,
    output logic                timer_irq_o
);

    logic [DATA_W-1:0] mtime_q;
    logic [DATA_W-1:0] mtime_d;
    logic [DATA_W-1:0] mtimecmp_q;
    logic [DATA_W-1:0] mtimecmp_d;

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    // A write to mtime replaces the increment for that cycle
    always_comb begin
        mtime_d    = mtime_q + 1'b1;
        mtimecmp_d = mtimecmp_q;
        if (req_i && we_i) begin
            if (addr_i == TIMER_CMP_OFS[2]) begin
                mtimecmp_d = apply_be(mtimecmp_q, wdata_i, be_i);
            end else begin
                mtime_d = apply_be(mtime_q, wdata_i, be_i);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------
    // Irq follows the next-state compare so it lines up with the response
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            timer_irq_o <= 1'b0;
        end else begin
            mtime_q     <= mtime_d;
            mtimecmp_q  <= mtimecmp_d;
            timer_irq_o <= (mtime_d >= mtimecmp_d);
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            rdata_o <= (addr_i == TIMER_MTIME_OFS[2]) ? mtime_q : mtimecmp_q;
        end
    end

endmodule

`default_nettype wire

/* source/sram.sv */
// Single-port SRAM with byte enables
// Word addressed, read data registered one cycle after the strobe

`default_nettype none

module sram import harness_pkg::*; (
    input  logic                          clk_i,
    input  logic                          req_i,
    input  logic                          we_i,
    input  logic [$clog2(SRAM_WORDS)-1:0] addr_i,
    input  logic [DATA_W/8-1:0]           be_i,
    input  logic [DATA_W-1:0]             wdata_i,
    output logic [DATA_W-1:0]             rdata_o
);

    logic [DATA_W-1:0] mem_q [SRAM_WORDS];

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                // Disabled lanes keep their old bytes
                mem_q[addr_i] <= apply_be(mem_q[addr_i], wdata_i, be_i);
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

/* source/boot_rom.sv */
// Boot ROM holding a short stub that jumps into SRAM

`default_nettype none

module boot_rom import harness_pkg::*; (
    input  logic                         clk_i,
    input  logic                         req_i,
    input  logic [$clog2(ROM_WORDS)-1:0] addr_i,
    output logic [DATA_W-1:0]            rdata_o
);

    logic [DATA_W-1:0] word;

    // Jump to SRAM base as lui t0 then jalr x0 through t0
    // Every word after the jump is a nop
    always_comb begin
        case (addr_i)
            'd0:     word = {SRAM_BASE[ADDR_W-1:12], 5'd5, 7'b0110111};
            'd1:     word = 32'h0002_8067;
            default: word = 32'h0000_0013;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= word;
        end
    end

endmodule

`default_nettype wire

/* source/addr_decoder.sv */
// Address decoder for the harness bus
// Routes a request to ROM, SRAM or timer and returns one response at a time

`default_nettype none

module addr_decoder import harness_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  bus_req_t            req_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    output bus_resp_t           resp_o,
    output logic                resp_valid_o,
    input  logic                resp_ready_i,
    output logic                rom_req_o,
    output logic                sram_req_o,
    output logic                timer_req_o,
    output logic                tgt_we_o,
    output logic [ADDR_W-1:0]   tgt_addr_o,
    output logic [DATA_W/8-1:0] tgt_be_o,
    output logic [DATA_W-1:0]   tgt_wdata_o,
    input  logic [DATA_W-1:0]   rom_rdata_i,
    input  logic [DATA_W-1:0]   sram_rdata_i,
    input  logic [DATA_W-1:0]   timer_rdata_i
);

    target_e tgt;
    logic    is_write;
    logic    req_fire;
    logic    err;
    logic    resp_valid_q;
    target_e tgt_q;
    src_e    src_q;
    logic    err_q;
    logic    write_q;

    function automatic logic in_region(
        input logic [ADDR_W-1:0] addr,
        input logic [ADDR_W-1:0] base,
        input logic [ADDR_W-1:0] size
    );
        return (addr >= base) && ((addr - base) < size);
    endfunction

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------
    always_comb begin
        if (in_region(req_i.addr, ROM_BASE, ADDR_W'(ROM_WORDS * 4))) begin
            tgt = TGT_ROM;
        end else if (in_region(req_i.addr, SRAM_BASE, ADDR_W'(SRAM_WORDS * 4))) begin
            tgt = TGT_SRAM;
        end else if (in_region(req_i.addr, TIMER_BASE, TIMER_CMP_OFS + 4)) begin
            tgt = TGT_TIMER;
        end else begin
            tgt = TGT_NONE;
        end
    end

    assign is_write = (req_i.op == OP_WRITE);
    assign err      = (tgt == TGT_NONE) || ((tgt == TGT_ROM) && is_write);

    // Only one transaction in flight
    assign req_ready_o = ~resp_valid_q;
    assign req_fire    = req_valid_i & req_ready_o;

    // ROM writes never reach the ROM
    assign rom_req_o   = req_fire & (tgt == TGT_ROM) & ~is_write;
    assign sram_req_o  = req_fire & (tgt == TGT_SRAM);
    assign timer_req_o = req_fire & (tgt == TGT_TIMER);

    assign tgt_we_o    = is_write;
    assign tgt_addr_o  = req_i.addr;
    assign tgt_be_o    = req_i.be;
    assign tgt_wdata_o = req_i.wdata;

    // ------------------------------------------------------------------------
    // Response
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            resp_valid_q <= 1'b0;
        end else if (req_fire) begin
            resp_valid_q <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            tgt_q   <= tgt;
            src_q   <= req_i.src;
            err_q   <= err;
            write_q <= is_write;
        end
    end

    // Target read registers only change on a strobe, and no strobe
    // can occur while the response is held, so the selected data is stable
    always_comb begin
        resp_o.src   = src_q;
        resp_o.err   = err_q;
        resp_o.rdata = '0;
        if (!err_q && !write_q) begin
            case (tgt_q)
                TGT_ROM:   resp_o.rdata = rom_rdata_i;
                TGT_SRAM:  resp_o.rdata = sram_rdata_i;
                TGT_TIMER: resp_o.rdata = timer_rdata_i;
                default:   resp_o.rdata = '0;
            endcase
        end
    end

    assign resp_valid_o = resp_valid_q;

endmodule

`default_nettype wire

/* source/req_arbiter.sv */
// Request arbiter for the core and debug ports
// Round-robin grant, source tagging and response steering by src

`default_nettype none

module req_arbiter import harness_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // Core-side port
    input  bus_req_t  core_req_i,
    input  logic      core_req_valid_i,
    output logic      core_req_ready_o,
    output bus_resp_t core_resp_o,
    output logic      core_resp_valid_o,
    input  logic      core_resp_ready_i,
    // Debug port
    input  bus_req_t  dbg_req_i,
    input  logic      dbg_req_valid_i,
    output logic      dbg_req_ready_o,
    output bus_resp_t dbg_resp_o,
    output logic      dbg_resp_valid_o,
    input  logic      dbg_resp_ready_i,
    // Towards the decoder
    output bus_req_t  arb_req_o,
    output logic      arb_req_valid_o,
    input  logic      arb_req_ready_i,
    input  bus_resp_t dec_resp_i,
    input  logic      dec_resp_valid_i,
    output logic      dec_resp_ready_o
);

    src_e last_q;
    src_e sel;

    // ------------------------------------------------------------------------
    // Request path
    // ------------------------------------------------------------------------
    // On contention the port that lost last time wins
    always_comb begin
        if (core_req_valid_i && dbg_req_valid_i) begin
            sel = (last_q == SRC_CORE) ? SRC_DEBUG : SRC_CORE;
        end else if (dbg_req_valid_i) begin
            sel = SRC_DEBUG;
        end else begin
            sel = SRC_CORE;
        end
    end

    always_comb begin
        arb_req_o     = (sel == SRC_DEBUG) ? dbg_req_i : core_req_i;
        arb_req_o.src = sel;
    end

    assign arb_req_valid_o  = core_req_valid_i | dbg_req_valid_i;
    assign core_req_ready_o = arb_req_ready_i & (sel == SRC_CORE);
    assign dbg_req_ready_o  = arb_req_ready_i & (sel == SRC_DEBUG);

    // Starts at debug so the core wins the first tie
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_q <= SRC_DEBUG;
        end else if (arb_req_valid_o && arb_req_ready_i) begin
            last_q <= sel;
        end
    end

    // ------------------------------------------------------------------------
    // Response path
    // ------------------------------------------------------------------------
    // The tag carried back by the decoder selects the port
    assign core_resp_o       = dec_resp_i;
    assign dbg_resp_o        = dec_resp_i;
    assign core_resp_valid_o = dec_resp_valid_i & (dec_resp_i.src == SRC_CORE);
    assign dbg_resp_valid_o  = dec_resp_valid_i & (dec_resp_i.src == SRC_DEBUG);
    assign dec_resp_ready_o  = (dec_resp_i.src == SRC_DEBUG) ? dbg_resp_ready_i
                                                             : core_resp_ready_i;

endmodule

`default_nettype wire

/* source/harness_pkg.sv */
// Harness bus definitions
// Address map, request and response structs, opcodes and a byte merge helper

`default_nettype none

package harness_pkg;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    localparam logic [ADDR_W-1:0] ROM_BASE  = 32'h0001_0000;
    localparam int                ROM_WORDS = 16;

    localparam logic [ADDR_W-1:0] SRAM_BASE  = 32'h8000_0000;
    localparam int                SRAM_WORDS = 256;

    // Timer occupies two words
    localparam logic [ADDR_W-1:0] TIMER_BASE      = 32'h0200_0000;
    localparam logic [ADDR_W-1:0] TIMER_MTIME_OFS = 32'd0;
    localparam logic [ADDR_W-1:0] TIMER_CMP_OFS   = 32'd4;

    // ------------------------------------------------------------------------
    // Bus types
    // ------------------------------------------------------------------------
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    typedef enum logic {
        SRC_CORE  = 1'b0,
        SRC_DEBUG = 1'b1
    } src_e;

    typedef enum logic [1:0] {
        TGT_ROM   = 2'd0,
        TGT_SRAM  = 2'd1,
        TGT_TIMER = 2'd2,
        TGT_NONE  = 2'd3
    } target_e;

    // Masters leave src at zero, the arbiter fills it in
    typedef struct packed {
        bus_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W/8-1:0] be;
        logic [DATA_W-1:0]   wdata;
        src_e                src;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
        src_e              src;
    } bus_resp_t;

    // Replace only the byte lanes selected by be
    function automatic logic [DATA_W-1:0] apply_be(
        input logic [DATA_W-1:0]   old_data,
        input logic [DATA_W-1:0]   new_data,
        input logic [DATA_W/8-1:0] be
    );
        logic [DATA_W-1:0] merged;
        merged = old_data;
        for (int i = 0; i < DATA_W / 8; i++) begin
            if (be[i]) begin
                merged[i*8 +: 8] = new_data[i*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire
